// ==== gomoku_vcf.f ====
design/gomoku_board_pkg.sv
design/search_pkg.sv
design/cand_if.sv
design/node_link_if.sv
design/threat_scan.sv
design/search_node.sv
design/move_report.sv
design/gomoku_vcf_solver.sv
test/tb_clock_gen.sv
test/tb_gomoku_vcf.sv

// ==== Bender.yml ====
package:
  name: gomoku_vcf

sources:
  - design/gomoku_board_pkg.sv
  - design/search_pkg.sv
  - design/cand_if.sv
  - design/node_link_if.sv
  - design/threat_scan.sv
  - design/search_node.sv
  - design/move_report.sv
  - design/gomoku_vcf_solver.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_gomoku_vcf.sv

// ==== test/tb_gomoku_vcf.sv ====
// searches run one at a time at MAX_DEPTH 5; the reference solver is exponential, keep boards sparse
`timescale 1ns/1ps

module tb_gomoku_vcf
    import gomoku_board_pkg::*;
    import search_pkg::*;
();

    localparam int MAX_DEPTH      = 5;
    localparam int N_SEARCHES     = 29;
    localparam int TIMEOUT_CYCLES = N_SEARCHES * 100000;

    logic        i_clk;
    logic        gen_rst_n;
    logic        force_rst_n;
    logic        i_rst_n;
    logic        i_start;
    board_t      i_board;
    logic        o_done;
    logic        o_win;
    coord_t      o_x;
    coord_t      o_y;

    int          errors      = 0;
    int          test_errors = 0;
    int          n_pass      = 0;
    int          n_fail      = 0;
    int          n_expected  = 0;
    int          n_done      = 0;
    int          cycle_count = 0;
    int unsigned seed;
    string       cur_name;
    logic [31:0] exp_win;
    logic [31:0] exp_x;
    logic [31:0] exp_y;
    board_t      work_board;

    assign i_rst_n = gen_rst_n & force_rst_n;

    tb_clock_gen u_clk (
        .o_clk   (i_clk),
        .o_rst_n (gen_rst_n)
    );

    gomoku_vcf_solver #(
        .MAX_DEPTH (MAX_DEPTH)
    ) gomoku_vcf_solver_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (i_start),
        .i_board (i_board),
        .o_done  (o_done),
        .o_win   (o_win),
        .o_x     (o_x),
        .o_y     (o_y)
    );

    // attacker stones in five cells from (r0, c0) along (dr, dc); -1 if off the board
    function automatic int count_run(input board_t b, input int r0, input int c0,
                                     input int dr, input int dc, output int n_empty);
        int n_atk;
        int r;
        int c;
        n_atk   = 0;
        n_empty = 0;
        for (int j = 0; j < 5; j++) begin
            r = r0 + j * dr;
            c = c0 + j * dc;
            if (r < 0 || r >= BOARD_N || c < 0 || c >= BOARD_N) begin
                return -1;
            end
            if (b[r * BOARD_N + c] == CELL_ATK) begin
                n_atk++;
            end else if (b[r * BOARD_N + c] == CELL_EMPTY) begin
                n_empty++;
            end
        end
        return n_atk;
    endfunction

    // does an attacker stone on idx complete a five or make a four
    function automatic void attacker_stone_effect(input board_t b, input int idx,
                                                  output bit five, output bit four);
        int     dr [4];
        int     dc [4];
        int     n;
        int     ne;
        board_t trial;
        dr    = '{0, 1, 1, 1};
        dc    = '{1, 0, 1, -1};
        trial = b;
        trial[idx] = CELL_ATK;
        five = 1'b0;
        four = 1'b0;
        for (int d = 0; d < 4; d++) begin
            for (int s = 0; s < 5; s++) begin
                n = count_run(trial, idx / BOARD_N - s * dr[d], idx % BOARD_N - s * dc[d],
                              dr[d], dc[d], ne);
                if (n == 5) begin
                    five = 1'b1;
                end
                if (n == 4 && ne == 1) begin
                    four = 1'b1;
                end
            end
        end
    endfunction

    // expected verdict of one ply; move_idx is the winning cell, 0 on a loss
    function automatic bit ref_solve(input board_t b, input int level, output int move_idx);
        bit     atk;
        bit     five;
        bit     four;
        bit     win;
        bit     result;
        int     win_idx;
        int     count;
        int     sub_move;
        int     list [MAX_CAND];
        board_t child;
        atk      = (level % 2 == 0);
        win      = 1'b0;
        win_idx  = 0;
        count    = 0;
        move_idx = 0;
        for (int i = 0; i < CELLS; i++) begin
            if (b[i] == CELL_EMPTY) begin
                attacker_stone_effect(b, i, five, four);
                if (atk && five && !win) begin
                    win     = 1'b1;
                    win_idx = i;
                end
                if ((atk ? four : five) && count < MAX_CAND) begin
                    list[count] = i;
                    count++;
                end
            end
        end
        if (win) begin
            move_idx = win_idx;
            return 1'b1;
        end
        if (level == MAX_DEPTH - 1 || count == 0) begin
            return 1'b0;
        end
        for (int k = 0; k < count; k++) begin
            child = b;
            child[list[k]] = atk ? CELL_ATK : CELL_DEF;
            result = ref_solve(child, level + 1, sub_move);
            if (atk && result) begin
                move_idx = list[k];
                return 1'b1;
            end
            if (!atk && !result) begin
                return 1'b0;
            end
        end
        return !atk;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s %s: expected %0d, actual %0d", cur_name, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic clear_board();
        for (int i = 0; i < CELLS; i++) begin
            work_board[i] = CELL_EMPTY;
        end
    endtask

    task automatic place_line(input int r, input int c, input int dr, input int dc,
                              input int n, input cell_t v);
        for (int k = 0; k < n; k++) begin
            work_board[(r + k * dr) * BOARD_N + c + k * dc] = v;
        end
    endtask

    // stones land in rows and columns 3 to 11
    task automatic random_board(input int n_atk, input int n_def);
        int placed;
        int idx;
        clear_board();
        placed = 0;
        while (placed < n_atk + n_def) begin
            idx = (3 + $urandom % 9) * BOARD_N + 3 + $urandom % 9;
            if (work_board[idx] == CELL_EMPTY) begin
                work_board[idx] = (placed < n_atk) ? CELL_ATK : CELL_DEF;
                placed++;
            end
        end
    endtask

    task automatic begin_test(input string name);
        cur_name    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            n_pass++;
            $display("ok    %s", cur_name);
        end else begin
            n_fail++;
            $display("bad   %s (%0d mismatches)", cur_name, test_errors);
        end
    endtask

    task automatic start_search();
        int mi;
        @(negedge i_clk);
        exp_win = ref_solve(work_board, 0, mi);
        exp_x   = exp_win ? mi / BOARD_N : 0;
        exp_y   = exp_win ? mi % BOARD_N : 0;
        i_board = work_board;
        i_start = 1'b1;
        n_expected++;
        @(negedge i_clk);
        i_start = 1'b0;
    endtask

    task automatic run_search();
        start_search();
        wait (n_done == n_expected);
    endtask

    task automatic check_move(input int win, input int x, input int y);
        check_value("o_win (hand)", win, o_win);
        check_value("o_x (hand)", x, o_x);
        check_value("o_y (hand)", y, o_y);
    endtask

    // open four across row 10 and a vertical four in column 12
    task automatic two_fives_board();
        clear_board();
        place_line(10, 5, 0, 1, 4, CELL_ATK);
        place_line(3, 12, 1, 0, 4, CELL_ATK);
    endtask

    // a four at (7,5) forces (6,5), then (7,7) is a double four
    task automatic double_four_board();
        clear_board();
        place_line(2, 7, 0, 1, 1, CELL_DEF);
        place_line(3, 7, 1, 0, 3, CELL_ATK);
        // shuts the anti-diagonal through (4,7), (6,5) and (7,4)
        place_line(5, 6, 0, 1, 1, CELL_DEF);
        place_line(7, 2, 0, 1, 1, CELL_DEF);
        place_line(7, 3, 0, 1, 2, CELL_ATK);
        place_line(8, 5, 1, 0, 3, CELL_ATK);
        place_line(11, 5, 0, 1, 1, CELL_DEF);
    endtask

    // compares every o_done against the expected result of the outstanding search
    always @(negedge i_clk) begin
        if (o_done === 1'b1) begin
            if (n_done >= n_expected) begin
                $display("%s: o_done pulsed with no search outstanding", cur_name);
                errors++;
                test_errors++;
            end else begin
                check_value("o_win", exp_win, o_win);
                check_value("o_x", exp_x, o_x);
                check_value("o_y", exp_y, o_y);
                n_done++;
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: o_done never arrived within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        i_start     = 1'b0;
        force_rst_n = 1'b1;
        clear_board();
        i_board = work_board;
        seed    = 32'hf03c;
        void'($urandom(seed));
        wait (gen_rst_n === 1'b1);

        begin_test("immediate_five");
        two_fives_board();
        run_search();
        check_move(1, 2, 12);
        end_test();

        begin_test("four_then_double_four");
        double_four_board();
        run_search();
        check_move(1, 7, 5);
        end_test();

        begin_test("empty_board");
        clear_board();
        run_search();
        check_move(0, 0, 0);
        end_test();

        begin_test("scattered_pairs");
        clear_board();
        place_line(2, 2, 0, 1, 2, CELL_ATK);
        place_line(8, 8, 1, 1, 2, CELL_ATK);
        place_line(12, 1, 0, 3, 2, CELL_ATK);
        place_line(5, 5, 0, 1, 1, CELL_DEF);
        run_search();
        check_move(0, 0, 0);
        end_test();

        begin_test("defended_lines");
        clear_board();
        place_line(7, 2, 0, 6, 2, CELL_DEF);
        place_line(7, 3, 0, 1, 3, CELL_ATK);
        place_line(8, 12, 0, 1, 1, CELL_DEF);
        place_line(9, 12, 1, 0, 3, CELL_ATK);
        run_search();
        check_move(0, 0, 0);
        end_test();

        // ten closed-three fours fill the list, the open three in row 13 is never reached
        begin_test("candidate_cap");
        clear_board();
        place_line(1, 0, 0, 8, 2, CELL_DEF);
        place_line(1, 1, 0, 1, 3, CELL_ATK);
        place_line(1, 9, 0, 1, 3, CELL_ATK);
        place_line(4, 5, 0, 1, 1, CELL_DEF);
        place_line(4, 6, 0, 1, 3, CELL_ATK);
        place_line(7, 0, 0, 1, 1, CELL_DEF);
        place_line(7, 1, 0, 1, 3, CELL_ATK);
        place_line(10, 5, 0, 1, 1, CELL_DEF);
        place_line(10, 6, 0, 1, 3, CELL_ATK);
        place_line(13, 5, 0, 1, 3, CELL_ATK);
        run_search();
        check_move(0, 0, 0);
        end_test();

        for (int k = 0; k < 20; k++) begin
            begin_test($sformatf("random_%0d", k));
            random_board(10, 6);
            run_search();
            end_test();
        end

        // an empty board offered mid-search must not be taken
        begin_test("second_start_ignored");
        two_fives_board();
        start_search();
        repeat (10) @(negedge i_clk);
        clear_board();
        i_board = work_board;
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        wait (n_done == n_expected);
        check_move(1, 2, 12);
        repeat (300) @(negedge i_clk);
        end_test();

        // the move outputs still hold (2,12) from the search before
        begin_test("reset_mid_search");
        double_four_board();
        @(negedge i_clk);
        i_board = work_board;
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        repeat (40) @(negedge i_clk);
        force_rst_n = 1'b0;
        repeat (2) @(negedge i_clk);
        check_value("o_done in reset", 0, o_done);
        check_value("o_win in reset", 0, o_win);
        check_value("o_x in reset", 0, o_x);
        check_value("o_y in reset", 0, o_y);
        force_rst_n = 1'b1;
        repeat (300) @(negedge i_clk);
        check_value("o_win after reset", 0, o_win);
        run_search();
        check_move(1, 7, 5);
        end_test();

        $display("tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== test/tb_clock_gen.sv ====
// free-running 4 ns clock; reset is low from time zero for two rising edges
`timescale 1ns/1ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #2 o_clk = ~o_clk;
        end
    end

    // release away from the rising edge
    initial begin
        o_rst_n = 1'b0;
        repeat (2) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

// ==== design/gomoku_vcf_solver.sv ====
// MAX_DEPTH must be odd; i_board is sampled once per accepted i_start, which is ignored while busy
`timescale 1ns/1ps

module gomoku_vcf_solver
    import gomoku_board_pkg::*;
#(
    parameter int MAX_DEPTH = 5
) (
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_start,
    input  board_t i_board,
    output logic   o_done,
    output logic   o_win,
    output coord_t o_x,
    output coord_t o_y
);

    logic   busy;
    logic   accept;
    logic   root_start;
    board_t root_board;
    coord_t move_x [MAX_DEPTH];
    coord_t move_y [MAX_DEPTH];

    // link g feeds level g; the last one hangs off the leaf
    node_link_if links [MAX_DEPTH+1] ();

    assign accept = i_start && !busy;

    always_ff @(posedge i_clk, negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy       <= 1'b0;
            root_start <= 1'b0;
        end else begin
            root_start <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (links[0].done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            root_board <= i_board;
        end
    end

    assign links[0].start = root_start;
    assign links[0].board = root_board;

    // nothing answers below the leaf
    assign links[MAX_DEPTH].done     = 1'b0;
    assign links[MAX_DEPTH].atk_wins = 1'b0;

    for (genvar g = 0; g < MAX_DEPTH; g++) begin : g_level
        search_node #(
            .LEVEL     (g),
            .MAX_DEPTH (MAX_DEPTH)
        ) u_node (
            .i_clk    (i_clk),
            .i_rst_n  (i_rst_n),
            .up       (links[g].child),
            .down     (links[g+1].parent),
            .o_move_x (move_x[g]),
            .o_move_y (move_y[g])
        );
    end

    move_report u_report (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (root_start),
        .i_root_done (links[0].done),
        .i_root_win  (links[0].atk_wins),
        .i_root_x    (move_x[0]),
        .i_root_y    (move_y[0]),
        .o_done      (o_done),
        .o_win       (o_win),
        .o_x         (o_x),
        .o_y         (o_y)
    );

endmodule

// ==== design/move_report.sv ====
// o_x and o_y mean something only with o_win set; they read 0 after a lost search
`timescale 1ns/1ps

module move_report
    import gomoku_board_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_start,
    input  logic   i_root_done,
    input  logic   i_root_win,
    input  coord_t i_root_x,
    input  coord_t i_root_y,
    output logic   o_done,
    output logic   o_win,
    output coord_t o_x,
    output coord_t o_y
);

    always_ff @(posedge i_clk, negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_done <= 1'b0;
            o_win  <= 1'b0;
            o_x    <= '0;
            o_y    <= '0;
        end else begin
            // root done is already a single-cycle pulse
            o_done <= i_root_done;
            if (i_start) begin
                o_win <= 1'b0;
            end else if (i_root_done) begin
                o_win <= i_root_win;
                if (i_root_win) begin
                    o_x <= i_root_x;
                    o_y <= i_root_y;
                end else begin
                    o_x <= '0;
                    o_y <= '0;
                end
            end
        end
    end

endmodule

// ==== design/search_node.sv ====
// one ply; the node at LEVEL MAX_DEPTH-1 never starts a child; moves are x = row, y = column
`timescale 1ns/1ps

module search_node
    import gomoku_board_pkg::*;
    import search_pkg::*;
#(
    parameter int LEVEL     = 0,
    parameter int MAX_DEPTH = 5
) (
    input  logic        i_clk,
    input  logic        i_rst_n,
    node_link_if.child  up,
    node_link_if.parent down,
    output coord_t      o_move_x,
    output coord_t      o_move_y
);

    // even levels move for the attacker
    localparam bit    IS_ATK  = (LEVEL % 2 == 0);
    localparam bit    IS_LEAF = (LEVEL == MAX_DEPTH - 1);
    localparam cell_t STONE   = IS_ATK ? CELL_ATK : CELL_DEF;

    node_state_t           state;
    logic [CAND_CNT_W-1:0] ptr;
    logic                  verdict;
    logic                  child_start;
    logic                  scan_start;
    logic                  last_cand;
    cand_t                 move;
    cand_t                 pick;
    board_t                child_next;
    board_t                child_board;

    cand_if cand_bus ();

    // a start that arrives mid-search is dropped
    assign scan_start = up.start && (state == ST_IDLE);

    threat_scan #(
        .MAX_CAND (MAX_CAND)
    ) u_scan (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (scan_start),
        .i_board    (up.board),
        .i_atk_turn (IS_ATK),
        .cand       (cand_bus.scanner)
    );

    assign pick      = cand_bus.list[ptr];
    assign last_cand = (ptr + 1'b1 == cand_bus.count);

    // our board plus one stone on the current candidate
    always_comb begin
        child_next = up.board;
        child_next[cell_index(pick.row, pick.col)] = STONE;
    end

    assign down.start  = child_start;
    assign down.board  = child_board;
    assign up.done     = (state == ST_DONE);
    assign up.atk_wins = verdict;
    assign o_move_x    = move.row;
    assign o_move_y    = move.col;

    always_ff @(posedge i_clk, negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= ST_IDLE;
            ptr         <= '0;
            verdict     <= 1'b0;
            child_start <= 1'b0;
            move        <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (up.start) begin
                        state <= ST_SCAN;
                    end
                end
                ST_SCAN: begin
                    if (cand_bus.done) begin
                        if (IS_ATK && cand_bus.win) begin
                            verdict <= 1'b1;
                            move    <= cand_bus.win_cell;
                            state   <= ST_DONE;
                        end else if (IS_LEAF || cand_bus.count == '0) begin
                            // out of depth, or the last move was not forcing
                            verdict <= 1'b0;
                            state   <= ST_DONE;
                        end else begin
                            ptr   <= '0;
                            state <= ST_PICK;
                        end
                    end
                end
                ST_PICK: begin
                    child_start <= 1'b1;
                    state       <= ST_WAIT_CHILD;
                end
                ST_WAIT_CHILD: begin
                    child_start <= 1'b0;
                    if (down.done) begin
                        // attacker stops on a win, defender on a refutation
                        if (down.atk_wins == IS_ATK) begin
                            verdict <= IS_ATK;
                            if (IS_ATK) begin
                                move <= pick;
                            end
                            state <= ST_DONE;
                        end else if (last_cand) begin
                            verdict <= !IS_ATK;
                            state   <= ST_DONE;
                        end else begin
                            ptr   <= ptr + 1'b1;
                            state <= ST_PICK;
                        end
                    end
                end
                ST_DONE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == ST_PICK) begin
            child_board <= child_next;
        end
    end

endmodule

// ==== design/threat_scan.sv ====
// only attacker fives and fours are found; defender stones just block; MAX_CAND <= list size of cand_if
`timescale 1ns/1ps

module threat_scan
    import gomoku_board_pkg::*;
    import search_pkg::*;
#(
    parameter int MAX_CAND = search_pkg::MAX_CAND
) (
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_start,
    input  board_t  i_board,
    input  logic    i_atk_turn,
    cand_if.scanner cand
);

    // row and column step of the four line directions
    localparam int DR [4] = '{0, 1, 1, 1};
    localparam int DC [4] = '{1, 0, 1, -1};

    scan_state_t state;
    coord_t      cur_row;
    coord_t      cur_col;
    cand_t       here;
    logic        cell_empty;
    logic        makes_five;
    logic        makes_four;
    logic        is_cand;
    logic        has_room;

    assign here       = '{row: cur_row, col: cur_col};
    assign cell_empty = (i_board[cell_index(cur_row, cur_col)] == CELL_EMPTY);
    assign is_cand    = cell_empty && (i_atk_turn ? makes_four : makes_five);
    assign has_room   = (cand.count < MAX_CAND);
    assign cand.done  = (state == SC_DONE);

    // every run of five through the current cell, in all four directions
    always_comb begin
        int   r;
        int   c;
        int   n_atk;
        int   n_empty;
        logic fits;
        makes_five = 1'b0;
        makes_four = 1'b0;
        for (int d = 0; d < 4; d++) begin
            for (int k = 0; k < 5; k++) begin
                n_atk   = 0;
                n_empty = 0;
                fits    = 1'b1;
                for (int j = 0; j < 5; j++) begin
                    r = int'(cur_row) + (j - k) * DR[d];
                    c = int'(cur_col) + (j - k) * DC[d];
                    if (r < 0 || r >= BOARD_N || c < 0 || c >= BOARD_N) begin
                        fits = 1'b0;
                    end else if (j != k) begin
                        if (i_board[r * BOARD_N + c] == CELL_ATK) begin
                            n_atk++;
                        end else if (i_board[r * BOARD_N + c] == CELL_EMPTY) begin
                            n_empty++;
                        end
                    end
                end
                // the other four cells decide what a stone here would make
                if (fits && n_atk == 4) begin
                    makes_five = 1'b1;
                end
                if (fits && n_atk == 3 && n_empty == 1) begin
                    makes_four = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk, negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= SC_IDLE;
            cur_row    <= '0;
            cur_col    <= '0;
            cand.count <= '0;
            cand.win   <= 1'b0;
        end else if (i_start) begin
            state      <= SC_RUN;
            cur_row    <= '0;
            cur_col    <= '0;
            cand.count <= '0;
            cand.win   <= 1'b0;
        end else if (state == SC_RUN) begin
            // count saturates at the cap
            if (is_cand && has_room) begin
                cand.count <= cand.count + 1'b1;
            end
            if (i_atk_turn && cell_empty && makes_five) begin
                cand.win <= 1'b1;
            end
            if (cur_col == BOARD_N - 1) begin
                cur_col <= '0;
                if (cur_row == BOARD_N - 1) begin
                    state <= SC_DONE;
                end else begin
                    cur_row <= cur_row + 1'b1;
                end
            end else begin
                cur_col <= cur_col + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == SC_RUN && !i_start) begin
            if (is_cand && has_room) begin
                cand.list[cand.count] <= here;
            end
            // first completing cell in scan order
            if (i_atk_turn && cell_empty && makes_five && !cand.win) begin
                cand.win_cell <= here;
            end
        end
    end

endmodule

// ==== design/node_link_if.sv ====
// the parent holds board stable from its start pulse until the child's done pulse
`timescale 1ns/1ps

interface node_link_if import gomoku_board_pkg::*; ();

    // parent to child
    logic   start;
    board_t board;

    // child to parent
    logic   done;
    logic   atk_wins;

    modport parent (
        output start, board,
        input  done, atk_wins
    );

    modport child (
        input  start, board,
        output done, atk_wins
    );

endinterface

// ==== design/cand_if.sv ====
// contents are valid only while done is high; list entries at or above count are stale
`timescale 1ns/1ps

interface cand_if import search_pkg::*; ();

    logic                      done;
    logic                      win;
    cand_t                     win_cell;
    logic [CAND_CNT_W-1:0]     count;
    cand_t [MAX_CAND-1:0]      list;

    modport scanner (
        output done, win, win_cell, count, list
    );

    modport node (
        input done, win, win_cell, count, list
    );

endinterface

// ==== design/search_pkg.sv ====
// candidate lists hold at most MAX_CAND cells; the count field must also hold MAX_CAND itself
package search_pkg;

    import gomoku_board_pkg::*;

    localparam int MAX_CAND   = 8;
    localparam int CAND_CNT_W = $clog2(MAX_CAND + 1);

    // one candidate cell
    typedef struct packed {
        coord_t row;
        coord_t col;
    } cand_t;

    // per-ply search FSM
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SCAN,
        ST_PICK,
        ST_WAIT_CHILD,
        ST_DONE
    } node_state_t;

    // threat scanner FSM
    typedef enum logic [1:0] {
        SC_IDLE,
        SC_RUN,
        SC_DONE
    } scan_state_t;

endpackage

// ==== design/gomoku_board_pkg.sv ====
// fixed 15x15 board; cell 0 is the top-left corner and cells run row by row
package gomoku_board_pkg;

    localparam int BOARD_N = 15;
    localparam int CELLS   = BOARD_N * BOARD_N;

    // occupancy of one intersection
    typedef enum logic [1:0] {
        CELL_EMPTY = 2'd0,
        CELL_ATK   = 2'd1,
        CELL_DEF   = 2'd2
    } cell_t;

    // element i holds row i / 15, column i % 15
    typedef cell_t [CELLS-1:0] board_t;

    typedef logic [3:0] coord_t;
    typedef logic [7:0] cell_idx_t;

    // flat board index of a row and column
    function automatic cell_idx_t cell_index(input coord_t row, input coord_t col);
        return cell_idx_t'(row * BOARD_N + col);
    endfunction

endpackage
